// ==== wb_pkg.sv ====
package wb_pkg;

    // datapath widths
    localparam int LANES       = 4;
    localparam int DATA_W      = 64;
    localparam int ADDR_W      = 32;
    localparam int REG_IDX_W   = 3;
    localparam int NUM_REGS    = 1 << REG_IDX_W;
    localparam int SEG_W       = 16;
    localparam int EFLAGS_W    = 18;
    localparam int IE_TYPE_W   = 4;
    localparam int FETCH_ALIGN = 4;                    // 16-byte fetch lines

    localparam int WBAQ_DEPTH  = 4;
    localparam int WBAQ_PTR_W  = $clog2(WBAQ_DEPTH);

    // memory access sizes
    localparam logic [1:0] MSZ_BYTE  = 2'b00;
    localparam logic [1:0] MSZ_WORD  = 2'b01;
    localparam logic [1:0] MSZ_DWORD = 2'b10;
    localparam logic [1:0] MSZ_QWORD = 2'b11;

    typedef enum logic [1:0] {
        OP_NORMAL   = 2'd0,
        OP_HALT     = 2'd1,
        OP_FAR_XFER = 2'd2                             // far jmp/call/ret, loads eip and cs
    } wb_op_e;

    // one retiring micro-op as held in the input latch
    typedef struct packed {
        wb_op_e                       op;
        logic [LANES-1:0][DATA_W-1:0] lane_data;
        logic [LANES-1:0][ADDR_W-1:0] lane_dest;       // reg index in low bits, or mem address
        logic [LANES-1:0]             lane_is_reg;
        logic [LANES-1:0]             lane_is_seg;
        logic [LANES-1:0]             lane_is_mem;
        logic [LANES-1:0]             lane_wb;
        logic [1:0]                   inp_size;
        logic [3:0]                   mem_size_ovr;    // one-hot size override
        logic [ADDR_W-1:0]            eip;
        logic                         ie;
        logic [IE_TYPE_W-1:0]         ie_type;
        logic                         interrupt;
        logic                         br_valid;
        logic                         br_taken;
        logic                         br_correct;
        logic [ADDR_W-1:0]            br_fip;
        logic [ADDR_W-1:0]            br_fip_p1;
        logic [SEG_W-1:0]             cs;
        logic [EFLAGS_W-1:0]          eflags;
    } wb_uop_t;

endpackage

// ==== wb_commit_if.sv ====
interface wb_commit_if import wb_pkg::*; (
    input logic clk
);

    logic [LANES-1:0]                reg_ld;
    logic [LANES-1:0]                seg_ld;
    logic [LANES-1:0][REG_IDX_W-1:0] dest_idx;
    logic [LANES-1:0][DATA_W-1:0]    lane_data;

    // single store picked for the wbaq
    logic                            mem_ld;
    logic [ADDR_W-1:0]               mem_addr;
    logic [DATA_W-1:0]               mem_data;
    logic [1:0]                      mem_size;

    modport producer (
        input  clk,
        output reg_ld, seg_ld, dest_idx, lane_data,
        output mem_ld, mem_addr, mem_data, mem_size
    );

    modport gpr_cons (input reg_ld, dest_idx, lane_data);

    modport seg_cons (input seg_ld, dest_idx, lane_data);  // only low SEG_W bits are used

    modport mem_cons (input mem_ld, mem_addr, mem_data, mem_size);

endinterface

// ==== wb_latch.sv ====
module wb_latch import wb_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    in_valid,
    input  logic    stall,
    input  wb_uop_t uop_d,
    output wb_uop_t uop_q,
    output logic    valid_q
);

    logic load;

    assign load = in_valid && !stall;

    // valid follows the input unless the stage is stalled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= in_valid;                       // drops after an empty cycle
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            uop_q <= uop_d;
        end
    end

endmodule

// ==== wb_stage.sv ====
module wb_stage import wb_pkg::*; (
    input  wb_uop_t              uop,
    input  logic                 valid_q,
    input  logic                 wbaq_full,
    wb_commit_if.producer        commit,
    output logic                 stall,
    output logic [ADDR_W-1:0]    new_eip,
    output logic [ADDR_W-1:0]    new_fip_e,
    output logic [ADDR_W-1:0]    new_fip_o,
    output logic [SEG_W-1:0]     cs_out,
    output logic [EFLAGS_W-1:0]  eflags_out,
    output logic                 resteer,
    output logic                 ie_val,
    output logic [IE_TYPE_W-1:0] ie_type_out,
    output logic                 halt
);

    logic [LANES-1:0]             lane_mem;
    logic [LANES-1:0]             mem_sel;
    logic [LANES-1:0][DATA_W-1:0] res;
    logic                         commit_ok;
    logic                         far_xfer;
    logic [ADDR_W-1:0]            fip_al;
    logic [ADDR_W-1:0]            fip_p1_al;
    logic [ADDR_W-1:0]            taken_eip;

    assign far_xfer = (uop.op == OP_FAR_XFER);
    assign lane_mem = uop.lane_is_mem & uop.lane_wb;

    // a pending store into a full queue blocks the whole micro-op
    assign stall     = valid_q && wbaq_full && (|lane_mem);
    assign commit_ok = valid_q && !stall;

    assign commit.reg_ld = {LANES{commit_ok}} & uop.lane_is_reg & uop.lane_wb;
    assign commit.seg_ld = {LANES{commit_ok}} & uop.lane_is_seg & uop.lane_wb;
    assign commit.mem_ld = commit_ok && (|lane_mem);

    assign mem_sel = lane_mem & (~lane_mem + 1'b1);    // lowest set bit

    // far transfer carries the selector in bits 47:32 of lane 0
    always_comb begin
        res = uop.lane_data;
        if (far_xfer) begin
            res[0] = {{(DATA_W-SEG_W){1'b0}}, uop.lane_data[0][ADDR_W+SEG_W-1:ADDR_W]};
        end
        for (int i = 0; i < LANES; i++) begin
            commit.dest_idx[i] = uop.lane_dest[i][REG_IDX_W-1:0];
        end
    end

    assign commit.lane_data = res;

    always_comb begin
        commit.mem_addr = '0;
        commit.mem_data = '0;
        for (int i = 0; i < LANES; i++) begin
            if (mem_sel[i]) begin
                commit.mem_addr = uop.lane_dest[i];
                commit.mem_data = res[i];
            end
        end
    end

    // override wins, then far transfer, then the op size
    always_comb begin
        if (uop.mem_size_ovr[0]) begin
            commit.mem_size = MSZ_BYTE;
        end else if (uop.mem_size_ovr[1]) begin
            commit.mem_size = MSZ_WORD;
        end else if (uop.mem_size_ovr[2]) begin
            commit.mem_size = MSZ_DWORD;
        end else if (uop.mem_size_ovr[3] || far_xfer) begin
            commit.mem_size = MSZ_QWORD;
        end else begin
            commit.mem_size = uop.inp_size;
        end
    end

    // even/odd fetch lines after a branch
    assign fip_al    = {uop.br_fip[ADDR_W-1:FETCH_ALIGN], {FETCH_ALIGN{1'b0}}};
    assign fip_p1_al = {uop.br_fip_p1[ADDR_W-1:FETCH_ALIGN], {FETCH_ALIGN{1'b0}}};
    assign new_fip_e = uop.br_fip[FETCH_ALIGN] ? fip_p1_al : fip_al;
    assign new_fip_o = uop.br_fip[FETCH_ALIGN] ? fip_al : fip_p1_al;

    assign taken_eip = far_xfer ? uop.lane_data[0][ADDR_W-1:0] : uop.br_fip;
    assign new_eip   = uop.br_taken ? taken_eip : uop.eip;

    assign cs_out     = uop.cs;
    assign eflags_out = uop.eflags;

    assign resteer = valid_q && uop.br_valid && !uop.br_correct;  // mispredict

    assign ie_val      = valid_q && (uop.ie || uop.interrupt);
    assign ie_type_out = {uop.interrupt, uop.ie_type[IE_TYPE_W-2:0]};

    assign halt = valid_q && (uop.op == OP_HALT);

    // upstream never sends more than one store per micro-op
    a_one_store : assert property (
        @(posedge commit.clk)
        valid_q |-> $onehot0(lane_mem)
    );

endmodule

// ==== gpr_file.sv ====
module gpr_file import wb_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    wb_commit_if.gpr_cons        commit,
    input  logic [REG_IDX_W-1:0] rd_addr,
    output logic [DATA_W-1:0]    rd_data
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    // lanes applied in order so the highest lane wins a collision
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < LANES; l++) begin
                if (commit.reg_ld[l]) begin
                    regs[commit.dest_idx[l]] <= commit.lane_data[l];
                end
            end
        end
    end

    assign rd_data = regs[rd_addr];                    // async read

    // loaded lanes must carry a known index from the stage
    for (genvar g = 0; g < LANES; g++) begin : g_idx_chk
        a_known_idx : assert property (
            @(posedge clk) disable iff (!arst_n)
            commit.reg_ld[g] |-> !$isunknown(commit.dest_idx[g])
        );
    end

endmodule

// ==== seg_file.sv ====
module seg_file import wb_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    wb_commit_if.seg_cons        commit,
    input  logic [REG_IDX_W-1:0] rd_addr,
    output logic [SEG_W-1:0]     rd_data
);

    logic [SEG_W-1:0] sregs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                sregs[r] <= '0;
            end
        end else begin
            // higher lane overwrites lower on same index
            for (int l = 0; l < LANES; l++) begin
                if (commit.seg_ld[l]) begin
                    sregs[commit.dest_idx[l]] <= commit.lane_data[l][SEG_W-1:0];
                end
            end
        end
    end

    assign rd_data = sregs[rd_addr];

endmodule

// ==== wbaq.sv ====
module wbaq import wb_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    wb_commit_if.mem_cons     commit,
    output logic              full,
    output logic              mem_valid,
    input  logic              mem_ready,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_data,
    output logic [1:0]        mem_size
);

    logic [ADDR_W-1:0]     addr_q [WBAQ_DEPTH];
    logic [DATA_W-1:0]     data_q [WBAQ_DEPTH];
    logic [1:0]            size_q [WBAQ_DEPTH];
    logic [WBAQ_PTR_W-1:0] wr_ptr;
    logic [WBAQ_PTR_W-1:0] rd_ptr;
    logic [WBAQ_PTR_W:0]   count;
    logic                  push;
    logic                  pop;

    assign push = commit.mem_ld;
    assign pop  = mem_valid && mem_ready;

    assign full      = (count == (WBAQ_PTR_W+1)'(WBAQ_DEPTH));
    assign mem_valid = (count != '0);

    // head entry shown directly, fall-through
    assign mem_addr = addr_q[rd_ptr];
    assign mem_data = data_q[rd_ptr];
    assign mem_size = size_q[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;         // depth is a power of two
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + push - pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[wr_ptr] <= commit.mem_addr;
            data_q[wr_ptr] <= commit.mem_data;
            size_q[wr_ptr] <= commit.mem_size;
        end
    end

    // stage must stall instead of pushing into a full queue
    a_no_push_full : assert property (
        @(posedge clk) disable iff (!arst_n)
        push |-> !full
    );

    // a drain only takes a slot that holds a store
    a_no_drain_empty : assert property (
        @(posedge clk) disable iff (!arst_n)
        pop |-> (rd_ptr != wr_ptr) || full
    );

endmodule

// ==== wb_top.sv ====
module wb_top import wb_pkg::*; (
    input  logic                         clk,
    input  logic                         arst_n,
    // retiring micro-op
    input  logic                         in_valid,
    output logic                         in_ready,
    input  wb_op_e                       op,
    input  logic [LANES-1:0][DATA_W-1:0] lane_data,
    input  logic [LANES-1:0][ADDR_W-1:0] lane_dest,
    input  logic [LANES-1:0]             lane_is_reg,
    input  logic [LANES-1:0]             lane_is_seg,
    input  logic [LANES-1:0]             lane_is_mem,
    input  logic [LANES-1:0]             lane_wb,
    input  logic [1:0]                   inp_size,
    input  logic [3:0]                   mem_size_ovr,
    input  logic [ADDR_W-1:0]            eip,
    input  logic                         ie,
    input  logic [IE_TYPE_W-1:0]         ie_type,
    input  logic                         interrupt,
    input  logic                         br_valid,
    input  logic                         br_taken,
    input  logic                         br_correct,
    input  logic [ADDR_W-1:0]            br_fip,
    input  logic [ADDR_W-1:0]            br_fip_p1,
    input  logic [SEG_W-1:0]             cs,
    input  logic [EFLAGS_W-1:0]          eflags,
    // register read ports
    input  logic [REG_IDX_W-1:0]         gpr_rd_addr,
    output logic [DATA_W-1:0]            gpr_rd_data,
    input  logic [REG_IDX_W-1:0]         seg_rd_addr,
    output logic [SEG_W-1:0]             seg_rd_data,
    // store drain
    output logic                         mem_valid,
    input  logic                         mem_ready,
    output logic [ADDR_W-1:0]            mem_addr,
    output logic [DATA_W-1:0]            mem_data,
    output logic [1:0]                   mem_size,
    // stage results
    output logic [ADDR_W-1:0]            new_eip,
    output logic [ADDR_W-1:0]            new_fip_e,
    output logic [ADDR_W-1:0]            new_fip_o,
    output logic [SEG_W-1:0]             cs_out,
    output logic [EFLAGS_W-1:0]          eflags_out,
    output logic                         resteer,
    output logic                         ie_val,
    output logic [IE_TYPE_W-1:0]         ie_type_out,
    output logic                         halt
);

    wb_uop_t uop_d;
    wb_uop_t uop_q;
    logic    valid_q;
    logic    stall;
    logic    wbaq_full;

    assign uop_d = '{op: op, lane_data: lane_data, lane_dest: lane_dest,
                     lane_is_reg: lane_is_reg, lane_is_seg: lane_is_seg,
                     lane_is_mem: lane_is_mem, lane_wb: lane_wb, inp_size: inp_size,
                     mem_size_ovr: mem_size_ovr, eip: eip, ie: ie, ie_type: ie_type,
                     interrupt: interrupt, br_valid: br_valid, br_taken: br_taken,
                     br_correct: br_correct, br_fip: br_fip, br_fip_p1: br_fip_p1,
                     cs: cs, eflags: eflags};

    assign in_ready = !stall;

    wb_commit_if i_commit (.clk(clk));

    wb_latch i_latch (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .stall(stall),
        .uop_d(uop_d), .uop_q(uop_q), .valid_q(valid_q)
    );

    wb_stage i_stage (
        .uop(uop_q), .valid_q(valid_q), .wbaq_full(wbaq_full), .commit(i_commit.producer),
        .stall(stall), .new_eip(new_eip), .new_fip_e(new_fip_e), .new_fip_o(new_fip_o),
        .cs_out(cs_out), .eflags_out(eflags_out), .resteer(resteer), .ie_val(ie_val),
        .ie_type_out(ie_type_out), .halt(halt)
    );

    gpr_file i_gpr (
        .clk(clk), .arst_n(arst_n), .commit(i_commit.gpr_cons),
        .rd_addr(gpr_rd_addr), .rd_data(gpr_rd_data)
    );

    seg_file i_seg (
        .clk(clk), .arst_n(arst_n), .commit(i_commit.seg_cons),
        .rd_addr(seg_rd_addr), .rd_data(seg_rd_data)
    );

    wbaq i_wbaq (
        .clk(clk), .arst_n(arst_n), .commit(i_commit.mem_cons), .full(wbaq_full),
        .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
        .mem_data(mem_data), .mem_size(mem_size)
    );

endmodule

// ==== tb_wb_top.sv ====
module tb_wb_top import wb_pkg::*; ();

    localparam int TOTAL_UOPS = 140;                   // micro-ops issued over all tests

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [1:0]        size;
    } store_t;

    typedef struct packed {
        logic [ADDR_W-1:0]            new_eip;
        logic [ADDR_W-1:0]            fip_e;
        logic [ADDR_W-1:0]            fip_o;
        logic                         resteer;
        logic                         ie_val;
        logic [IE_TYPE_W-1:0]         ie_type;
        logic                         halt;
        logic [LANES-1:0][DATA_W-1:0] val;             // lane values after the far fixup
        logic                         has_store;
        store_t                       st;
    } exp_t;

    logic                 clk = 1'b0;
    logic                 arst_n;
    logic                 in_valid;
    logic                 in_ready;
    logic [REG_IDX_W-1:0] gpr_rd_addr;
    logic [DATA_W-1:0]    gpr_rd_data;
    logic [REG_IDX_W-1:0] seg_rd_addr;
    logic [SEG_W-1:0]     seg_rd_data;
    logic                 mem_valid;
    logic                 mem_ready;
    logic [ADDR_W-1:0]    mem_addr;
    logic [DATA_W-1:0]    mem_data;
    logic [1:0]           mem_size;
    logic [ADDR_W-1:0]    new_eip;
    logic [ADDR_W-1:0]    new_fip_e;
    logic [ADDR_W-1:0]    new_fip_o;
    logic [SEG_W-1:0]     cs_out;
    logic [EFLAGS_W-1:0]  eflags_out;
    logic                 resteer;
    logic                 ie_val;
    logic [IE_TYPE_W-1:0] ie_type_out;
    logic                 halt;

    wb_uop_t           cur;                            // micro-op on the input ports
    wb_uop_t           lat_uop;                        // model of the input latch
    logic              lat_valid;
    store_t            st_q [$];                       // stores still expected on the drain
    logic [DATA_W-1:0] gpr_sh [NUM_REGS];
    logic [SEG_W-1:0]  seg_sh [NUM_REGS];
    integer            seed = 42;
    int                ready_mode;                     // 0 ready, 1 random, 2 held low
    bit                chk_en;
    int                errors;
    int                n_checks;
    int                n_tests;
    int                n_drained;

    always #4 clk = ~clk;

    wb_top i_dut (
        .*,
        .op(cur.op), .lane_data(cur.lane_data), .lane_dest(cur.lane_dest),
        .lane_is_reg(cur.lane_is_reg), .lane_is_seg(cur.lane_is_seg),
        .lane_is_mem(cur.lane_is_mem), .lane_wb(cur.lane_wb), .inp_size(cur.inp_size),
        .mem_size_ovr(cur.mem_size_ovr), .eip(cur.eip), .ie(cur.ie), .ie_type(cur.ie_type),
        .interrupt(cur.interrupt), .br_valid(cur.br_valid), .br_taken(cur.br_taken),
        .br_correct(cur.br_correct), .br_fip(cur.br_fip), .br_fip_p1(cur.br_fip_p1),
        .cs(cur.cs), .eflags(cur.eflags)
    );

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    // mem_mode 0 no stores, 1 random stores, 2 exactly one store
    function automatic wb_uop_t gen_uop(input int mem_mode);
        wb_uop_t     u;
        logic [31:0] r;
        int          store_lane;
        bit          mem_used;
        u = '0;
        r = rnd();
        case (r[2:0])
            3'd5:       u.op = OP_HALT;
            3'd6, 3'd7: u.op = OP_FAR_XFER;
            default:    u.op = OP_NORMAL;
        endcase
        store_lane = (mem_mode == 2) ? int'(r[4:3]) : -1;
        mem_used = 1'b0;
        for (int l = 0; l < LANES; l++) begin
            u.lane_data[l] = {rnd(), rnd()};
            u.lane_dest[l] = rnd();
            r = rnd();
            u.lane_wb[l] = r[0];
            if (l == store_lane) begin
                u.lane_is_mem[l] = 1'b1;
                u.lane_wb[l] = 1'b1;
            end else if (mem_mode != 0 && r[2:1] == 2'd2) begin
                u.lane_is_mem[l] = 1'b1;               // extra mem lanes only without wb
                if (mem_mode == 2 || mem_used) u.lane_wb[l] = 1'b0;
                if (u.lane_wb[l]) mem_used = 1'b1;
            end else if (r[1]) begin
                u.lane_is_seg[l] = 1'b1;
            end else begin
                u.lane_is_reg[l] = 1'b1;
            end
        end
        r = rnd();
        u.inp_size = r[1:0];
        u.mem_size_ovr = r[7] ? (4'b0001 << r[6:5]) : 4'b0000;
        u.ie = r[8] & r[9];
        u.ie_type = r[13:10];
        u.interrupt = r[14] & r[15];
        u.br_valid = r[16];
        u.br_taken = r[17];
        u.br_correct = r[18] | r[19];
        u.eip = rnd();
        u.br_fip = rnd();
        u.br_fip_p1 = u.br_fip + 32'd16;               // next sequential fetch line
        r = rnd();
        u.cs = r[31:16];
        u.eflags = r[EFLAGS_W-1:0];
        return u;
    endfunction

    // expected stage outputs and commit effects of one valid micro-op
    function automatic exp_t predict(input wb_uop_t u);
        exp_t              e;
        logic              far;
        logic [ADDR_W-1:0] fa;
        logic [ADDR_W-1:0] fb;
        e = '0;
        far = (u.op == OP_FAR_XFER);
        e.val = u.lane_data;
        if (far) e.val[0] = {{(DATA_W-SEG_W){1'b0}}, u.lane_data[0][47:32]};
        for (int l = LANES - 1; l >= 0; l--) begin     // lowest store lane ends up chosen
            if (u.lane_is_mem[l] && u.lane_wb[l]) begin
                e.has_store = 1'b1;
                e.st.addr = u.lane_dest[l];
                e.st.data = e.val[l];
            end
        end
        case (u.mem_size_ovr)
            4'b0001: e.st.size = MSZ_BYTE;
            4'b0010: e.st.size = MSZ_WORD;
            4'b0100: e.st.size = MSZ_DWORD;
            4'b1000: e.st.size = MSZ_QWORD;
            default: e.st.size = far ? MSZ_QWORD : u.inp_size;
        endcase
        fa = {u.br_fip[ADDR_W-1:4], 4'h0};
        fb = {u.br_fip_p1[ADDR_W-1:4], 4'h0};
        e.fip_e = fa[4] ? fb : fa;
        e.fip_o = fa[4] ? fa : fb;
        if (!u.br_taken) e.new_eip = u.eip;
        else e.new_eip = far ? u.lane_data[0][ADDR_W-1:0] : u.br_fip;
        e.resteer = u.br_valid && !u.br_correct;
        e.ie_val = u.ie || u.interrupt;
        e.ie_type = {u.interrupt, u.ie_type[2:0]};
        e.halt = (u.op == OP_HALT);
        return e;
    endfunction

    task automatic check(input string name, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // tracks latch, queue occupancy and register contents edge by edge
    always @(posedge clk) begin : model
        exp_t                 e;
        logic                 stall_m;
        logic [REG_IDX_W-1:0] idx;
        e = predict(lat_uop);
        stall_m = lat_valid && e.has_store && (st_q.size() == WBAQ_DEPTH);
        if (!arst_n) begin
            lat_valid = 1'b0;
            st_q.delete();
            for (int r = 0; r < NUM_REGS; r++) begin
                gpr_sh[r] = '0;
                seg_sh[r] = '0;
            end
        end else begin
            if (mem_valid && mem_ready) begin
                n_drained++;
                if (st_q.size() == 0) begin
                    errors++;
                    $display("a store was drained at %0t while none was pending", $time);
                end else begin
                    check("mem_addr", mem_addr, st_q[0].addr);
                    check("mem_data", mem_data, st_q[0].data);
                    check("mem_size", mem_size, st_q[0].size);
                    void'(st_q.pop_front());
                end
            end
            if (lat_valid && !stall_m) begin
                for (int l = 0; l < LANES; l++) begin  // later lanes overwrite earlier
                    idx = lat_uop.lane_dest[l][REG_IDX_W-1:0];
                    if (lat_uop.lane_is_reg[l] && lat_uop.lane_wb[l]) gpr_sh[idx] = e.val[l];
                    if (lat_uop.lane_is_seg[l] && lat_uop.lane_wb[l])
                        seg_sh[idx] = e.val[l][SEG_W-1:0];
                end
                if (e.has_store) st_q.push_back(e.st);
            end
            if (!stall_m) begin
                if (in_valid) lat_uop = cur;
                lat_valid = in_valid;
            end
        end
    end

    always @(negedge clk) begin : compare
        exp_t e;
        if (chk_en) begin
            e = predict(lat_uop);
            check("in_ready", in_ready,
                  !(lat_valid && e.has_store && st_q.size() == WBAQ_DEPTH));
            check("mem_valid", mem_valid, st_q.size() != 0);
            check("resteer", resteer, lat_valid && e.resteer);
            check("ie_val", ie_val, lat_valid && e.ie_val);
            check("halt", halt, lat_valid && e.halt);
            if (lat_valid) begin
                check("new_eip", new_eip, e.new_eip);
                check("new_fip_e", new_fip_e, e.fip_e);
                check("new_fip_o", new_fip_o, e.fip_o);
                check("ie_type_out", ie_type_out, e.ie_type);
                check("cs_out", cs_out, lat_uop.cs);
                check("eflags_out", eflags_out, lat_uop.eflags);
            end
        end
    end

    task automatic next_cycle();
        @(negedge clk);
        case (ready_mode)
            0:       mem_ready = 1'b1;
            1:       mem_ready = rnd() > 32'h6000_0000;
            default: mem_ready = 1'b0;
        endcase
    endtask

    task automatic issue(input wb_uop_t u);
        cur = u;
        in_valid = 1'b1;
        while (!in_ready) next_cycle();                // hold until the latch takes it
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (lat_valid || st_q.size() != 0 || mem_valid) next_cycle();
        next_cycle();
    endtask

    task automatic read_regs();
        for (int i = 0; i < NUM_REGS; i++) begin
            gpr_rd_addr = REG_IDX_W'(i);
            seg_rd_addr = REG_IDX_W'(i);
            next_cycle();
            check($sformatf("gpr_rd_data[%0d]", i), gpr_rd_data, gpr_sh[i]);
            check($sformatf("seg_rd_data[%0d]", i), seg_rd_data, seg_sh[i]);
        end
    endtask

    task automatic end_test(input string name, input int err0);
        n_tests++;
        $display("test %0d %s: %s", n_tests, name, (errors == err0) ? "ok" : "errors");
    endtask

    initial begin : stimulus
        int      err0;
        int      drained0;
        wb_uop_t u;
        arst_n = 1'b0;
        in_valid = 1'b0;
        cur = '0;
        gpr_rd_addr = '0;
        seg_rd_addr = '0;
        mem_ready = 1'b0;
        ready_mode = 0;
        chk_en = 1'b0;
        lat_uop = '0;
        lat_valid = 1'b0;
        repeat (4) @(posedge clk);
        next_cycle();
        arst_n = 1'b1;
        next_cycle();
        chk_en = 1'b1;

        err0 = errors;
        repeat (40) issue(gen_uop(0));
        wait_idle();
        read_regs();
        end_test("register and segment writes", err0);

        err0 = errors;
        drained0 = n_drained;
        ready_mode = 1;
        repeat (30) issue(gen_uop(2));
        wait_idle();
        check("stores drained", n_drained - drained0, 30);
        end_test("memory stores", err0);

        err0 = errors;
        drained0 = n_drained;
        ready_mode = 2;
        mem_ready = 1'b0;
        repeat (5) issue(gen_uop(2));                  // four fill the queue, fifth stalls
        u = gen_uop(2);
        cur = u;
        in_valid = 1'b1;
        repeat (8) begin
            check("in_ready", in_ready, 1'b0);
            next_cycle();
        end
        ready_mode = 0;
        issue(u);
        ready_mode = 1;
        repeat (4) issue(gen_uop(2));
        wait_idle();
        check("stores drained", n_drained - drained0, 10);
        read_regs();
        end_test("back-pressure", err0);

        err0 = errors;
        repeat (40) begin
            issue(gen_uop(1));
            repeat (rnd() % 2) next_cycle();
        end
        wait_idle();
        end_test("branch outputs", err0);

        err0 = errors;
        repeat (19) begin
            issue(gen_uop(1));
            repeat (rnd() % 4) next_cycle();
        end
        wait_idle();
        u = gen_uop(0);
        u.op = OP_HALT;
        u.ie = 1'b1;
        u.br_valid = 1'b1;
        u.br_correct = 1'b0;
        chk_en = 1'b0;
        issue(u);
        arst_n = 1'b0;                                 // reset while the latch is full
        #1;
        check("resteer", resteer, 1'b0);
        check("ie_val", ie_val, 1'b0);
        check("halt", halt, 1'b0);
        check("mem_valid", mem_valid, 1'b0);
        check("in_ready", in_ready, 1'b1);
        repeat (2) next_cycle();
        arst_n = 1'b1;
        next_cycle();
        chk_en = 1'b1;
        read_regs();
        end_test("exceptions, halt and reset", err0);

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TOTAL_UOPS * 20 + 200) @(posedge clk);
        $display("timeout after %0d cycles, the run did not complete", TOTAL_UOPS * 20 + 200);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== compile.f ====
wb_pkg.sv
wb_commit_if.sv
wb_latch.sv
wb_stage.sv
gpr_file.sv
seg_file.sv
wbaq.sv
wb_top.sv
tb_wb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= tb_wb_top
MDIR      ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN  := $(MDIR)/V$(TOP)
SRCS := $(filter %.sv,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)
